// File: alu_unit.sv
`timescale 1ns/10ps

module alu_unit (
	input  logic            i_clk,
	input  logic            i_rstn,
	input  cpu_pkg::issue_t i_issue,
	output cpu_pkg::wb_t    o_wb
);

	cpu_pkg::word_t imm_ext;
	cpu_pkg::word_t result;

	assign imm_ext = cpu_pkg::sext_imm(i_issue.imm);

	always_comb begin
		case (i_issue.op)
			cpu_pkg::OP_ADD:  result = i_issue.rs_val + i_issue.rt_val;
			cpu_pkg::OP_SUB:  result = i_issue.rs_val - i_issue.rt_val;
			cpu_pkg::OP_AND:  result = i_issue.rs_val & i_issue.rt_val;
			cpu_pkg::OP_OR:   result = i_issue.rs_val | i_issue.rt_val;
			cpu_pkg::OP_ADDI: result = i_issue.rs_val + imm_ext;
			default:          result = '0;
		endcase
	end

	// result goes back one cycle after issue
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			o_wb <= '0;
		end else begin
			o_wb.valid <= i_issue.valid;
			o_wb.addr  <= i_issue.rd;
			o_wb.data  <= result;
		end
	end

	a_alu_ops_only: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_issue.valid |-> i_issue.op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB,
			cpu_pkg::OP_AND, cpu_pkg::OP_OR, cpu_pkg::OP_ADDI});

endmodule

// File: cpu_core.sv
`timescale 1ns/10ps

module cpu_core (
	input  logic            clk,
	input  logic            rstn,
	input  cpu_pkg::word_t  i_imem_rdata,
	input  cpu_pkg::word_t  i_dmem_rdata,
	output cpu_pkg::pc_t    o_imem_addr,
	output logic            o_imem_en,
	output cpu_pkg::daddr_t o_dmem_addr,
	output cpu_pkg::word_t  o_dmem_wdata,
	output logic            o_dmem_en,
	output logic            o_dmem_we,
	output logic            o_halted
);

	cpu_pkg::dec_instr_t dec;
	logic                hold;
	logic                halt_seen;
	logic                win_empty;
	logic                mem_busy;
	cpu_pkg::reg_addr_t  rs_addr [cpu_pkg::WIN_DEPTH];
	cpu_pkg::reg_addr_t  rt_addr [cpu_pkg::WIN_DEPTH];
	cpu_pkg::word_t      rs_val  [cpu_pkg::WIN_DEPTH];
	cpu_pkg::word_t      rt_val  [cpu_pkg::WIN_DEPTH];
	cpu_pkg::issue_t     alu_issue;
	cpu_pkg::issue_t     mem_issue;
	cpu_pkg::wb_t        alu_wb;
	cpu_pkg::wb_t        mem_wb;

	fetch_decode u_fetch (
		.i_clk        (clk),
		.i_rstn       (rstn),
		.i_imem_rdata (i_imem_rdata),
		.i_hold       (hold),
		.o_imem_addr  (o_imem_addr),
		.o_imem_en    (o_imem_en),
		.o_dec        (dec),
		.o_halt_seen  (halt_seen)
	);

	issue_window u_window (
		.i_clk       (clk),
		.i_rstn      (rstn),
		.i_dec       (dec),
		.i_alu_wb    (alu_wb),
		.i_mem_wb    (mem_wb),
		.i_rs_val    (rs_val),
		.i_rt_val    (rt_val),
		.o_rs_addr   (rs_addr),
		.o_rt_addr   (rt_addr),
		.o_alu_issue (alu_issue),
		.o_mem_issue (mem_issue),
		.o_hold      (hold),
		.o_empty     (win_empty)
	);

	reg_file u_regs (
		.i_clk     (clk),
		.i_rstn    (rstn),
		.i_rs_addr (rs_addr),
		.i_rt_addr (rt_addr),
		.i_alu_wb  (alu_wb),
		.i_mem_wb  (mem_wb),
		.o_rs_val  (rs_val),
		.o_rt_val  (rt_val)
	);

	alu_unit u_alu (
		.i_clk   (clk),
		.i_rstn  (rstn),
		.i_issue (alu_issue),
		.o_wb    (alu_wb)
	);

	mem_unit u_mem (
		.i_clk        (clk),
		.i_rstn       (rstn),
		.i_issue      (mem_issue),
		.i_dmem_rdata (i_dmem_rdata),
		.o_dmem_addr  (o_dmem_addr),
		.o_dmem_wdata (o_dmem_wdata),
		.o_dmem_en    (o_dmem_en),
		.o_dmem_we    (o_dmem_we),
		.o_wb         (mem_wb),
		.o_busy       (mem_busy)
	);

	// the last ALU writeback may still trail by a cycle
	assign o_halted = halt_seen && win_empty && !mem_busy;

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

	localparam int NUM_REGS  = 32;
	localparam int WIN_DEPTH = 3;

	// instruction field positions
	localparam int OP_MSB = 31;
	localparam int RD_LSB = 21;
	localparam int RS_LSB = 16;
	localparam int RT_LSB = 11;

	typedef logic [31:0]                   word_t;
	typedef logic [$clog2(NUM_REGS)-1:0]   reg_addr_t;
	typedef logic [11:0]                   pc_t;
	typedef logic [13:0]                   daddr_t;
	typedef logic [15:0]                   imm_t;
	typedef logic [$clog2(WIN_DEPTH)-1:0]  win_idx_t;

	typedef enum logic [5:0] {
		OP_NOP  = 6'h00,
		OP_ADD  = 6'h01,
		OP_SUB  = 6'h02,
		OP_AND  = 6'h03,
		OP_OR   = 6'h04,
		OP_ADDI = 6'h05,
		OP_LW   = 6'h06,
		OP_SW   = 6'h07,
		OP_HALT = 6'h3f
	} opcode_t;

	typedef enum logic {
		UNIT_ALU = 1'b0,
		UNIT_MEM = 1'b1
	} unit_t;

	typedef struct packed {
		logic      valid;
		opcode_t   op;
		unit_t     unit;
		reg_addr_t rd;
		reg_addr_t rs;
		reg_addr_t rt;
		imm_t      imm;
		logic      uses_rt;
		logic      writes_rd;
	} dec_instr_t;

	// one entry handed to a unit, operands already read
	typedef struct packed {
		logic      valid;
		opcode_t   op;
		reg_addr_t rd;
		word_t     rs_val;
		word_t     rt_val;
		imm_t      imm;
	} issue_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t addr;
		word_t     data;
	} wb_t;

	function automatic word_t sext_imm(input imm_t imm);
		return {{($bits(word_t) - $bits(imm_t)){imm[$bits(imm_t)-1]}}, imm};
	endfunction

endpackage

// File: fetch_decode.sv
`timescale 1ns/10ps

module fetch_decode (
	input  logic                i_clk,
	input  logic                i_rstn,
	input  cpu_pkg::word_t      i_imem_rdata,
	input  logic                i_hold,
	output cpu_pkg::pc_t        o_imem_addr,
	output logic                o_imem_en,
	output cpu_pkg::dec_instr_t o_dec,
	output logic                o_halt_seen
);

	cpu_pkg::pc_t        pc_q;
	logic                inflight_q;
	logic                skid_vld_q;
	cpu_pkg::word_t      skid_q;
	logic                halt_q;
	cpu_pkg::word_t      cur_word;
	logic                cur_vld;
	cpu_pkg::dec_instr_t cur_dec;

	function automatic cpu_pkg::dec_instr_t decode(input cpu_pkg::word_t w, input logic vld);
		cpu_pkg::dec_instr_t d;
		d.op  = cpu_pkg::opcode_t'(w[cpu_pkg::OP_MSB -: $bits(cpu_pkg::opcode_t)]);
		d.rd  = w[cpu_pkg::RD_LSB +: $bits(cpu_pkg::reg_addr_t)];
		d.rs  = w[cpu_pkg::RS_LSB +: $bits(cpu_pkg::reg_addr_t)];
		d.rt  = w[cpu_pkg::RT_LSB +: $bits(cpu_pkg::reg_addr_t)];
		d.imm = w[$bits(cpu_pkg::imm_t)-1:0];
		d.unit = (d.op == cpu_pkg::OP_LW || d.op == cpu_pkg::OP_SW) ?
			cpu_pkg::UNIT_MEM : cpu_pkg::UNIT_ALU;
		d.uses_rt = d.op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
			cpu_pkg::OP_OR, cpu_pkg::OP_SW};
		d.writes_rd = d.rd != '0 && d.op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB,
			cpu_pkg::OP_AND, cpu_pkg::OP_OR, cpu_pkg::OP_ADDI, cpu_pkg::OP_LW};
		// nop, halt and unknown codes never reach the window
		d.valid = vld && d.op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
			cpu_pkg::OP_OR, cpu_pkg::OP_ADDI, cpu_pkg::OP_LW, cpu_pkg::OP_SW};
		return d;
	endfunction

	assign o_imem_addr = pc_q;
	assign o_imem_en   = !i_hold && !halt_q;
	assign o_halt_seen = halt_q;

	// skid word and a fresh word never arrive together
	assign cur_word = skid_vld_q ? skid_q : i_imem_rdata;
	assign cur_vld  = (skid_vld_q || inflight_q) && !halt_q;
	assign cur_dec  = decode(cur_word, cur_vld);

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			pc_q       <= '0;
			inflight_q <= 1'b0;
			skid_vld_q <= 1'b0;
			halt_q     <= 1'b0;
			o_dec      <= '0;
		end else begin
			if (o_imem_en)
				pc_q <= pc_q + 1'b1;
			inflight_q <= o_imem_en;
			if (i_hold) begin
				if (inflight_q && !halt_q)
					skid_vld_q <= 1'b1;
			end else begin
				skid_vld_q <= 1'b0;
				o_dec      <= cur_dec;
				if (cur_vld && cur_dec.op == cpu_pkg::OP_HALT)
					halt_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_hold && inflight_q)
			skid_q <= i_imem_rdata;
	end

	a_skid_exclusive: assert property (@(posedge i_clk) disable iff (!i_rstn)
		!(skid_vld_q && inflight_q));

endmodule

// File: issue_window.sv
`timescale 1ns/10ps

module issue_window (
	input  logic                i_clk,
	input  logic                i_rstn,
	input  cpu_pkg::dec_instr_t i_dec,
	input  cpu_pkg::wb_t        i_alu_wb,
	input  cpu_pkg::wb_t        i_mem_wb,
	input  cpu_pkg::word_t      i_rs_val [cpu_pkg::WIN_DEPTH],
	input  cpu_pkg::word_t      i_rt_val [cpu_pkg::WIN_DEPTH],
	output cpu_pkg::reg_addr_t  o_rs_addr [cpu_pkg::WIN_DEPTH],
	output cpu_pkg::reg_addr_t  o_rt_addr [cpu_pkg::WIN_DEPTH],
	output cpu_pkg::issue_t     o_alu_issue,
	output cpu_pkg::issue_t     o_mem_issue,
	output logic                o_hold,
	output logic                o_empty
);

	// entry 0 is the oldest
	cpu_pkg::dec_instr_t           win_q   [cpu_pkg::WIN_DEPTH];
	cpu_pkg::dec_instr_t           win_nxt [cpu_pkg::WIN_DEPTH];
	logic [cpu_pkg::NUM_REGS-1:0]  busy_q;
	logic [cpu_pkg::NUM_REGS-1:0]  set_mask;
	logic [cpu_pkg::NUM_REGS-1:0]  clr_mask;
	logic [cpu_pkg::WIN_DEPTH-1:0] valid;
	logic [cpu_pkg::WIN_DEPTH-1:0] ready;
	logic [cpu_pkg::WIN_DEPTH-1:0] leaving;
	logic                          alu_go;
	logic                          mem_go;
	cpu_pkg::win_idx_t             alu_idx;
	cpu_pkg::win_idx_t             mem_idx;
	logic                          load_inflight_q;

	function automatic cpu_pkg::issue_t make_issue(input logic go,
		input cpu_pkg::dec_instr_t e, input cpu_pkg::word_t rs_val,
		input cpu_pkg::word_t rt_val);
		cpu_pkg::issue_t iss;
		iss.valid  = go;
		iss.op     = e.op;
		iss.rd     = e.writes_rd ? e.rd : '0;
		iss.rs_val = rs_val;
		iss.rt_val = rt_val;
		iss.imm    = e.imm;
		return iss;
	endfunction

	always_comb begin
		cpu_pkg::dec_instr_t e;
		cpu_pkg::dec_instr_t o;
		for (int i = 0; i < cpu_pkg::WIN_DEPTH; i++) begin
			e = win_q[i];
			valid[i]     = e.valid;
			o_rs_addr[i] = e.rs;
			o_rt_addr[i] = e.rt;
			// a busy destination also stalls, so each busy bit has one owner
			ready[i] = e.valid && !busy_q[e.rs] && !(e.uses_rt && busy_q[e.rt])
				&& !(e.writes_rd && busy_q[e.rd]);
			for (int j = 0; j < i; j++) begin
				o = win_q[j];
				if (o.valid) begin
					if (o.writes_rd && (o.rd == e.rs || (e.uses_rt && o.rd == e.rt)))
						ready[i] = 1'b0;
					if (e.writes_rd && (o.rs == e.rd || (o.uses_rt && o.rt == e.rd)
						|| (o.writes_rd && o.rd == e.rd)))
						ready[i] = 1'b0;
					// memory ops stay in program order
					if (e.unit == cpu_pkg::UNIT_MEM && o.unit == cpu_pkg::UNIT_MEM)
						ready[i] = 1'b0;
				end
			end
		end
	end

	// walk from youngest to oldest so the oldest ready entry wins
	always_comb begin
		alu_go  = 1'b0;
		alu_idx = '0;
		mem_go  = 1'b0;
		mem_idx = '0;
		for (int i = cpu_pkg::WIN_DEPTH - 1; i >= 0; i--) begin
			if (ready[i] && win_q[i].unit == cpu_pkg::UNIT_ALU) begin
				alu_go  = 1'b1;
				alu_idx = cpu_pkg::win_idx_t'(i);
			end
			if (ready[i] && win_q[i].unit == cpu_pkg::UNIT_MEM && !load_inflight_q) begin
				mem_go  = 1'b1;
				mem_idx = cpu_pkg::win_idx_t'(i);
			end
		end
		for (int i = 0; i < cpu_pkg::WIN_DEPTH; i++)
			leaving[i] = (alu_go && alu_idx == i) || (mem_go && mem_idx == i);
	end

	assign o_hold  = &valid && !alu_go && !mem_go;
	assign o_empty = !(|valid);

	// compact the survivors, then append the decoded instruction
	always_comb begin
		int cnt;
		cnt = 0;
		for (int i = 0; i < cpu_pkg::WIN_DEPTH; i++)
			win_nxt[i] = '0;
		for (int i = 0; i < cpu_pkg::WIN_DEPTH; i++) begin
			if (win_q[i].valid && !leaving[i]) begin
				win_nxt[cnt] = win_q[i];
				cnt++;
			end
		end
		if (i_dec.valid && !o_hold)
			win_nxt[cnt] = i_dec;
	end

	always_comb begin
		set_mask = '0;
		clr_mask = '0;
		if (alu_go && win_q[alu_idx].writes_rd)
			set_mask[win_q[alu_idx].rd] = 1'b1;
		if (mem_go && win_q[mem_idx].writes_rd)
			set_mask[win_q[mem_idx].rd] = 1'b1;
		if (i_alu_wb.valid)
			clr_mask[i_alu_wb.addr] = 1'b1;
		if (i_mem_wb.valid)
			clr_mask[i_mem_wb.addr] = 1'b1;
	end

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			for (int i = 0; i < cpu_pkg::WIN_DEPTH; i++)
				win_q[i] <= '0;
			busy_q          <= '0;
			load_inflight_q <= 1'b0;
			o_alu_issue     <= '0;
			o_mem_issue     <= '0;
		end else begin
			win_q  <= win_nxt;
			busy_q <= (busy_q & ~clr_mask) | set_mask;
			if (mem_go && win_q[mem_idx].op == cpu_pkg::OP_LW)
				load_inflight_q <= 1'b1;
			else if (i_mem_wb.valid)
				load_inflight_q <= 1'b0;
			o_alu_issue <= make_issue(alu_go, win_q[alu_idx], i_rs_val[alu_idx],
				i_rt_val[alu_idx]);
			o_mem_issue <= make_issue(mem_go, win_q[mem_idx], i_rs_val[mem_idx],
				i_rt_val[mem_idx]);
		end
	end

	a_wb_distinct: assert property (@(posedge i_clk) disable iff (!i_rstn)
		i_alu_wb.valid && i_mem_wb.valid && i_alu_wb.addr != '0
		|-> i_alu_wb.addr != i_mem_wb.addr);

	// both units never claim one register in the same cycle
	a_busy_once: assert property (@(posedge i_clk) disable iff (!i_rstn)
		alu_go && mem_go && win_q[alu_idx].writes_rd && win_q[mem_idx].writes_rd
		|-> win_q[alu_idx].rd != win_q[mem_idx].rd);

endmodule

// File: mem_unit.sv
`timescale 1ns/10ps

module mem_unit (
	input  logic            i_clk,
	input  logic            i_rstn,
	input  cpu_pkg::issue_t i_issue,
	input  cpu_pkg::word_t  i_dmem_rdata,
	output cpu_pkg::daddr_t o_dmem_addr,
	output cpu_pkg::word_t  o_dmem_wdata,
	output logic            o_dmem_en,
	output logic            o_dmem_we,
	output cpu_pkg::wb_t    o_wb,
	output logic            o_busy
);

	cpu_pkg::word_t     eff_addr;
	logic               issue_load;
	logic               rd_strobe;
	cpu_pkg::reg_addr_t s1_rd_q;
	cpu_pkg::reg_addr_t wb_rd_q;
	logic               wb_pend_q;

	assign eff_addr   = i_issue.rs_val + cpu_pkg::sext_imm(i_issue.imm);
	assign issue_load = i_issue.valid && i_issue.op == cpu_pkg::OP_LW;
	assign rd_strobe  = o_dmem_en && !o_dmem_we;

	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			o_dmem_en <= 1'b0;
			o_dmem_we <= 1'b0;
			wb_pend_q <= 1'b0;
		end else begin
			o_dmem_en <= i_issue.valid;
			o_dmem_we <= i_issue.valid && i_issue.op == cpu_pkg::OP_SW;
			wb_pend_q <= rd_strobe;
		end
	end

	// address, store data and load destination
	always_ff @(posedge i_clk) begin
		if (i_issue.valid) begin
			o_dmem_addr  <= cpu_pkg::daddr_t'(eff_addr);
			o_dmem_wdata <= i_issue.rt_val;
			s1_rd_q      <= i_issue.rd;
		end
		wb_rd_q <= s1_rd_q;
	end

	// load data comes straight from the memory port
	assign o_wb.valid = wb_pend_q;
	assign o_wb.addr  = wb_rd_q;
	assign o_wb.data  = i_dmem_rdata;

	assign o_busy = issue_load || rd_strobe || wb_pend_q;

endmodule

// File: reg_file.sv
`timescale 1ns/10ps

module reg_file (
	input  logic               i_clk,
	input  logic               i_rstn,
	input  cpu_pkg::reg_addr_t i_rs_addr [cpu_pkg::WIN_DEPTH],
	input  cpu_pkg::reg_addr_t i_rt_addr [cpu_pkg::WIN_DEPTH],
	input  cpu_pkg::wb_t       i_alu_wb,
	input  cpu_pkg::wb_t       i_mem_wb,
	output cpu_pkg::word_t     o_rs_val [cpu_pkg::WIN_DEPTH],
	output cpu_pkg::word_t     o_rt_val [cpu_pkg::WIN_DEPTH]
);

	cpu_pkg::word_t regs_q [cpu_pkg::NUM_REGS];

	// one write port per unit
	always_ff @(posedge i_clk) begin
		if (!i_rstn) begin
			for (int r = 0; r < cpu_pkg::NUM_REGS; r++)
				regs_q[r] <= '0;
		end else begin
			if (i_alu_wb.valid && i_alu_wb.addr != '0)
				regs_q[i_alu_wb.addr] <= i_alu_wb.data;
			if (i_mem_wb.valid && i_mem_wb.addr != '0)
				regs_q[i_mem_wb.addr] <= i_mem_wb.data;
		end
	end

	// two read ports per window entry
	always_comb begin
		for (int i = 0; i < cpu_pkg::WIN_DEPTH; i++) begin
			o_rs_val[i] = (i_rs_addr[i] == '0) ? '0 : regs_q[i_rs_addr[i]];
			o_rt_val[i] = (i_rt_addr[i] == '0) ? '0 : regs_q[i_rt_addr[i]];
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# build with Verilator, run, then scan the log for the fail message
rm -f sim.log \
	&& verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f sources.f -o tb_cpu \
	&& ./obj_dir/tb_cpu > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0

// File: sources.f
cpu_pkg.sv
fetch_decode.sv
issue_window.sv
reg_file.sv
alu_unit.sv
mem_unit.sv
cpu_core.sv
tb_cpu.sv

// File: tb_cpu.sv
`timescale 1ns/10ps

module tb_cpu;

	localparam int IMEM_WORDS  = 1 << $bits(cpu_pkg::pc_t);
	localparam int DMEM_WORDS  = 1 << $bits(cpu_pkg::daddr_t);
	localparam int CYCLE_LIMIT = 6 * 300;

	logic            clk        = 1'b0;
	logic            rstn       = 1'b0;
	cpu_pkg::word_t  imem_rdata = '0;
	cpu_pkg::word_t  dmem_rdata = '0;
	cpu_pkg::pc_t    imem_addr;
	logic            imem_en;
	cpu_pkg::daddr_t dmem_addr;
	cpu_pkg::word_t  dmem_wdata;
	logic            dmem_en;
	logic            dmem_we;
	logic            halted;

	cpu_pkg::word_t  imem     [IMEM_WORDS];
	cpu_pkg::word_t  dmem     [DMEM_WORDS];
	cpu_pkg::word_t  ref_mem  [DMEM_WORDS];
	cpu_pkg::word_t  ref_regs [cpu_pkg::NUM_REGS];
	cpu_pkg::word_t  prog     [$];
	cpu_pkg::daddr_t obs_addr [$];
	cpu_pkg::word_t  obs_data [$];
	cpu_pkg::daddr_t exp_addr [$];
	cpu_pkg::word_t  exp_data [$];
	cpu_pkg::word_t  lcg_state = 32'd94;
	int              sw_count  = 0;
	int              errors    = 0;
	int              checks    = 0;
	int              tests_run = 0;
	int              cycle_cnt = 0;

	cpu_core dut_i (
		.clk          (clk),
		.rstn         (rstn),
		.i_imem_rdata (imem_rdata),
		.i_dmem_rdata (dmem_rdata),
		.o_imem_addr  (imem_addr),
		.o_imem_en    (imem_en),
		.o_dmem_addr  (dmem_addr),
		.o_dmem_wdata (dmem_wdata),
		.o_dmem_en    (dmem_en),
		.o_dmem_we    (dmem_we),
		.o_halted     (halted)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		if (imem_en)
			imem_rdata <= imem[imem_addr];
	end

	// stores are logged in the order they reach the port
	always @(posedge clk) begin
		if (dmem_en && dmem_we) begin
			dmem[dmem_addr] = dmem_wdata;
			obs_addr.push_back(dmem_addr);
			obs_data.push_back(dmem_wdata);
		end else if (dmem_en) begin
			dmem_rdata <= dmem[dmem_addr];
		end
	end

	initial begin
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Errors found");
		$finish;
	end

	function automatic cpu_pkg::word_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic cpu_pkg::word_t sext16(input cpu_pkg::imm_t imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic cpu_pkg::word_t fill_pattern(input int a);
		return (cpu_pkg::word_t'(a) * 32'h0001_0003) ^ 32'h6b3c_9000;
	endfunction

	function automatic cpu_pkg::word_t rrr(input cpu_pkg::opcode_t op,
		input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rs,
		input cpu_pkg::reg_addr_t rt);
		return {op, rd, rs, rt, 11'd0};
	endfunction

	function automatic cpu_pkg::word_t rri(input cpu_pkg::opcode_t op,
		input cpu_pkg::reg_addr_t rd, input cpu_pkg::reg_addr_t rs, input cpu_pkg::imm_t imm);
		return {op, rd, rs, imm};
	endfunction

	// rt shares the top imm bits, so only 11 offset bits are free
	function automatic cpu_pkg::word_t sw_at(input cpu_pkg::reg_addr_t rt,
		input cpu_pkg::reg_addr_t rs, input logic [10:0] off);
		return {cpu_pkg::OP_SW, 5'd0, rs, rt, off};
	endfunction

	task automatic clear_program();
		prog.delete();
		sw_count = 0;
	endtask

	task automatic emit(input cpu_pkg::word_t w);
		prog.push_back(w);
		if (w[31:26] == cpu_pkg::OP_SW)
			sw_count++;
	endtask

	task automatic check_word(input cpu_pkg::word_t got, input cpu_pkg::word_t exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input cpu_pkg::daddr_t got, input cpu_pkg::daddr_t exp,
		input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// sequential execution, one instruction at a time
	task automatic model_run();
		cpu_pkg::word_t     w;
		cpu_pkg::word_t     res;
		cpu_pkg::daddr_t    a;
		cpu_pkg::reg_addr_t rd;
		cpu_pkg::reg_addr_t rs;
		cpu_pkg::reg_addr_t rt;
		logic               wr;
		int                 pc;
		foreach (ref_regs[r])
			ref_regs[r] = '0;
		pc = 0;
		while (pc < prog.size()) begin
			w   = prog[pc];
			pc++;
			rd  = w[25:21];
			rs  = w[20:16];
			rt  = w[15:11];
			a   = cpu_pkg::daddr_t'(ref_regs[rs] + sext16(w[15:0]));
			wr  = 1'b1;
			res = '0;
			case (w[31:26])
				cpu_pkg::OP_ADD:  res = ref_regs[rs] + ref_regs[rt];
				cpu_pkg::OP_SUB:  res = ref_regs[rs] - ref_regs[rt];
				cpu_pkg::OP_AND:  res = ref_regs[rs] & ref_regs[rt];
				cpu_pkg::OP_OR:   res = ref_regs[rs] | ref_regs[rt];
				cpu_pkg::OP_ADDI: res = ref_regs[rs] + sext16(w[15:0]);
				cpu_pkg::OP_LW:   res = ref_mem[a];
				cpu_pkg::OP_SW: begin
					wr = 1'b0;
					ref_mem[a] = ref_regs[rt];
					exp_addr.push_back(a);
					exp_data.push_back(ref_regs[rt]);
				end
				cpu_pkg::OP_HALT: begin
					wr = 1'b0;
					pc = prog.size();
				end
				default: wr = 1'b0;
			endcase
			if (wr && rd != '0)
				ref_regs[rd] = res;
		end
	endtask

	task automatic compare_results(input string name);
		int errs_before;
		int n;
		errs_before = errors;
		if (obs_addr.size() != sw_count) begin
			errors++;
			$display("Error at %0t: %s made %0d stores for %0d SW instructions", $time,
				name, obs_addr.size(), sw_count);
		end
		n = (obs_addr.size() < exp_addr.size()) ? obs_addr.size() : exp_addr.size();
		for (int i = 0; i < n; i++) begin
			check_addr(obs_addr[i], exp_addr[i], $sformatf("%s store %0d address", name, i));
			check_word(obs_data[i], exp_data[i], $sformatf("%s store %0d data", name, i));
		end
		for (int a = 0; a < DMEM_WORDS; a++)
			check_word(dmem[a], ref_mem[a], $sformatf("%s final dmem[%0h]", name, a));
		tests_run++;
		$display("%s: %0d stores, %0d mismatches", name, obs_addr.size(), errors - errs_before);
	endtask

	task automatic halt_and_run(input string name);
		emit(rri(cpu_pkg::OP_HALT, 5'd0, 5'd0, 16'd0));
		@(posedge clk);
		rstn <= 1'b0;
		@(negedge clk);
		for (int a = 0; a < IMEM_WORDS; a++)
			imem[a] = (a < prog.size()) ? prog[a] : {cpu_pkg::OP_HALT, 26'(a)};
		for (int a = 0; a < DMEM_WORDS; a++) begin
			dmem[a]    = fill_pattern(a);
			ref_mem[a] = dmem[a];
		end
		obs_addr.delete();
		obs_data.delete();
		exp_addr.delete();
		exp_data.delete();
		model_run();
		repeat (4) @(posedge clk);
		rstn <= 1'b1;
		do
			@(negedge clk);
		while (halted !== 1'b1);
		// last store strobe can trail o_halted
		repeat (2) @(posedge clk);
		@(negedge clk);
		compare_results(name);
	endtask

	task automatic dependent_alu_chain();
		clear_program();
		emit(rri(cpu_pkg::OP_ADDI, 5'd1, 5'd0, 16'd5));
		emit(sw_at(5'd1, 5'd0, 11'h101));
		emit(rri(cpu_pkg::OP_ADDI, 5'd2, 5'd1, 16'hfff9));
		emit(sw_at(5'd2, 5'd0, 11'h102));
		emit(rrr(cpu_pkg::OP_ADD, 5'd3, 5'd1, 5'd2));
		emit(sw_at(5'd3, 5'd0, 11'h103));
		emit(rrr(cpu_pkg::OP_SUB, 5'd4, 5'd3, 5'd1));
		emit(rrr(cpu_pkg::OP_AND, 5'd5, 5'd4, 5'd2));
		emit(rrr(cpu_pkg::OP_OR, 5'd6, 5'd5, 5'd1));
		emit(sw_at(5'd4, 5'd0, 11'h104));
		emit(sw_at(5'd6, 5'd0, 11'h106));
		emit(sw_at(5'd5, 5'd0, 11'h105));
		halt_and_run("alu_chain");
	endtask

	task automatic load_then_use();
		clear_program();
		emit(rri(cpu_pkg::OP_LW, 5'd1, 5'd0, 16'h0020));
		emit(rrr(cpu_pkg::OP_ADD, 5'd2, 5'd1, 5'd1));
		emit(sw_at(5'd2, 5'd0, 11'h200));
		emit(rri(cpu_pkg::OP_LW, 5'd3, 5'd0, 16'h0021));
		emit(rrr(cpu_pkg::OP_SUB, 5'd4, 5'd3, 5'd1));
		emit(sw_at(5'd4, 5'd0, 11'h201));
		halt_and_run("load_use");
	endtask

	// r3 and r4 do not wait for the load, so they pass the stalled add
	task automatic independent_past_load();
		clear_program();
		emit(rri(cpu_pkg::OP_LW, 5'd1, 5'd0, 16'h0030));
		emit(rrr(cpu_pkg::OP_ADD, 5'd2, 5'd1, 5'd1));
		emit(rri(cpu_pkg::OP_ADDI, 5'd3, 5'd0, 16'd9));
		emit(rrr(cpu_pkg::OP_OR, 5'd4, 5'd3, 5'd3));
		emit(sw_at(5'd3, 5'd0, 11'h210));
		emit(sw_at(5'd2, 5'd0, 11'h211));
		emit(sw_at(5'd4, 5'd0, 11'h212));
		halt_and_run("ooo_pass");
	endtask

	task automatic register_zero();
		clear_program();
		emit(rri(cpu_pkg::OP_ADDI, 5'd0, 5'd0, 16'h0055));
		emit(rri(cpu_pkg::OP_ADDI, 5'd1, 5'd0, 16'd3));
		emit(rrr(cpu_pkg::OP_ADD, 5'd0, 5'd1, 5'd1));
		emit(sw_at(5'd0, 5'd0, 11'h040));
		emit(sw_at(5'd1, 5'd0, 11'h041));
		emit(rri(cpu_pkg::OP_LW, 5'd0, 5'd0, 16'h0020));
		emit(rrr(cpu_pkg::OP_OR, 5'd2, 5'd0, 5'd1));
		emit(sw_at(5'd2, 5'd0, 11'h042));
		halt_and_run("reg_zero");
	endtask

	// each load address comes from the previous load
	task automatic dependent_load_chain();
		clear_program();
		emit(rri(cpu_pkg::OP_LW, 5'd1, 5'd0, 16'h0008));
		emit(sw_at(5'd1, 5'd0, 11'h381));
		for (int n = 2; n <= 8; n++) begin
			emit(rri(cpu_pkg::OP_LW, 5'(n), 5'(n - 1), 16'd0));
			emit(sw_at(5'(n), 5'd0, 11'(11'h380 + n)));
		end
		halt_and_run("load_chain");
	endtask

	task automatic random_program();
		cpu_pkg::word_t   r;
		cpu_pkg::word_t   s;
		cpu_pkg::opcode_t op;
		clear_program();
		for (int n = 0; n < 40; n++) begin
			r = lcg_next();
			s = lcg_next();
			case (r[30:28])
				3'd0:    op = cpu_pkg::OP_NOP;
				3'd1:    op = cpu_pkg::OP_ADD;
				3'd2:    op = cpu_pkg::OP_SUB;
				3'd3:    op = cpu_pkg::OP_AND;
				3'd4:    op = cpu_pkg::OP_OR;
				3'd5:    op = cpu_pkg::OP_ADDI;
				3'd6:    op = cpu_pkg::OP_LW;
				default: op = cpu_pkg::OP_SW;
			endcase
			// only r0 to r7, so dependencies are frequent
			if (op == cpu_pkg::OP_SW)
				emit(sw_at({2'b0, r[21:19]}, {2'b0, r[24:22]}, s[10:0]));
			else if (op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR})
				emit(rrr(op, {2'b0, r[27:25]}, {2'b0, r[24:22]}, {2'b0, r[21:19]}));
			else
				emit(rri(op, {2'b0, r[27:25]}, {2'b0, r[24:22]}, s[15:0]));
		end
		halt_and_run("random");
	endtask

	initial begin
		$timeformat(-9, 0, " ns", 0);
		dependent_alu_chain();
		load_then_use();
		independent_past_load();
		register_zero();
		dependent_load_chain();
		random_program();
		$display("%0d tests, %0d checks, %0d failed", tests_run, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
